// ==== Makefile ====
SEED      ?= 38
TOP       ?= tb_rv_core
LOG       ?= sim.log
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) -GSEED=$(SEED) \
		-f tb.f --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage import riscv_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  addr_t    pc_fd,
    input  inst_t    inst_fd,
    input  xlen_t    imm,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  xlen_t    rs1_val,
    input  xlen_t    rs2_val,
    input  reg_idx_t rd,
    input  alu_op_t  alu_op,
    input  logic     a_sel_pc,
    input  logic     b_sel_imm,
    input  logic     is_branch,
    input  logic     branch_ne,
    input  logic     is_load,
    input  logic     is_store,
    input  logic     is_csr,
    input  logic     reg_wen,
    input  logic     wb_en,
    input  reg_idx_t wb_rd,
    input  xlen_t    wb_val,
    output logic     br_taken,
    output addr_t    br_target,
    output xlen_t    alu_out,
    output xlen_t    store_data,
    output logic     is_load_x,
    output logic     is_store_x,
    output logic     reg_wen_x,
    output reg_idx_t rd_x,
    output xlen_t    tohost,
    output logic     tohost_valid
);
    addr_t       pc_x;
    xlen_t       imm_x;
    reg_idx_t    rs1_x;
    reg_idx_t    rs2_x;
    xlen_t       rs1_val_x;
    xlen_t       rs2_val_x;
    alu_op_t     alu_op_x;
    logic [11:0] csr_num_x;
    logic        a_sel_pc_x;
    logic        b_sel_imm_x;
    logic        is_branch_x;
    logic        branch_ne_x;
    logic        is_csr_x;
    xlen_t       rs1_fw;
    xlen_t       rs2_fw;
    xlen_t       alu_a;
    xlen_t       alu_b;
    logic        tohost_wr;

    // Writeback bypass, x0 never forwarded
    function automatic xlen_t fwd(input reg_idx_t idx, input xlen_t val,
                                  input logic en, input reg_idx_t w_idx, input xlen_t w_val);
        return (en && w_idx != '0 && w_idx == idx) ? w_val : val;
    endfunction

    // Control registers, reset to a bubble
    always_ff @(posedge clk) begin
        if (rst) begin
            is_branch_x <= 1'b0;
            is_load_x   <= 1'b0;
            is_store_x  <= 1'b0;
            is_csr_x    <= 1'b0;
            reg_wen_x   <= 1'b0;
        end else begin
            is_branch_x <= is_branch;
            is_load_x   <= is_load;
            is_store_x  <= is_store;
            is_csr_x    <= is_csr;
            reg_wen_x   <= reg_wen;
        end
    end

    // Operands, decode-side forwarding applied on the way in
    always_ff @(posedge clk) begin
        pc_x        <= pc_fd;
        imm_x       <= imm;
        rs1_x       <= rs1;
        rs2_x       <= rs2;
        rd_x        <= rd;
        rs1_val_x   <= fwd(rs1, rs1_val, wb_en, wb_rd, wb_val);
        rs2_val_x   <= fwd(rs2, rs2_val, wb_en, wb_rd, wb_val);
        alu_op_x    <= alu_op;
        a_sel_pc_x  <= a_sel_pc;
        b_sel_imm_x <= b_sel_imm;
        branch_ne_x <= branch_ne;
        csr_num_x   <= inst_fd[31:20];
    end

    // Result of the instruction just ahead, now in writeback
    assign rs1_fw = fwd(rs1_x, rs1_val_x, wb_en, wb_rd, wb_val);
    assign rs2_fw = fwd(rs2_x, rs2_val_x, wb_en, wb_rd, wb_val);

    assign alu_a = a_sel_pc_x ? pc_x : rs1_fw;
    assign alu_b = b_sel_imm_x ? imm_x : rs2_fw;

    always_comb begin
        case (alu_op_x)
            ALU_SUB:    alu_out = alu_a - alu_b;
            ALU_AND:    alu_out = alu_a & alu_b;
            ALU_OR:     alu_out = alu_a | alu_b;
            ALU_XOR:    alu_out = alu_a ^ alu_b;
            ALU_SLT:    alu_out = {31'b0, $signed(alu_a) < $signed(alu_b)};
            ALU_SLL:    alu_out = alu_a << alu_b[4:0];
            ALU_SRL:    alu_out = alu_a >> alu_b[4:0];
            ALU_PASS_B: alu_out = alu_b;
            default:    alu_out = alu_a + alu_b;
        endcase
    end

    // beq/bne, target is PC + imm out of the ALU
    assign br_taken   = is_branch_x && (branch_ne_x ? (rs1_fw != rs2_fw) : (rs1_fw == rs2_fw));
    assign br_target  = alu_out;
    assign store_data = rs2_fw;

    assign tohost_wr = is_csr_x && (csr_num_x == TOHOST_CSR);

    // Value holds between pulses
    always_ff @(posedge clk) begin
        if (rst) begin
            tohost       <= '0;
            tohost_valid <= 1'b0;
        end else begin
            tohost_valid <= tohost_wr;
            if (tohost_wr) begin
                tohost <= rs1_fw;
            end
        end
    end

endmodule

// ==== fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage import riscv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      run,
    input  logic      imem_wr_en,
    input  imem_idx_t imem_wr_addr,
    input  inst_t     imem_wr_data,
    input  logic      br_taken,
    input  addr_t     br_target,
    output addr_t     pc_fd,
    output inst_t     inst_fd
);
    inst_t     imem [IMEM_WORDS];
    inst_t     imem_q;
    addr_t     next_pc;
    imem_idx_t rd_idx;
    logic      rst_q;

    // Parked at the reset PC until the program is loaded
    always_comb begin
        if (!run) begin
            next_pc = RESET_PC;
        end else if (br_taken) begin
            next_pc = br_target;
        end else begin
            next_pc = pc_fd + 32'd4;
        end
    end

    assign rd_idx = next_pc[11:2];

    // Load port is only open while halted
    always_ff @(posedge clk) begin
        if (imem_wr_en && !run) begin
            imem[imem_wr_addr] <= imem_wr_data;
        end
        imem_q <= imem[rd_idx];
    end

    // pc_fd is the PC of the word now in imem_q
    always_ff @(posedge clk) begin
        rst_q <= rst;
        if (rst) begin
            pc_fd <= RESET_PC;
        end else begin
            pc_fd <= next_pc;
        end
    end

    // Slot behind a taken branch becomes a bubble
    assign inst_fd = (rst_q || !run || br_taken) ? NOP_INST : imem_q;

endmodule

// ==== inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder import riscv_pkg::*; (
    input  inst_t    inst,
    output xlen_t    imm,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    output reg_idx_t rd,
    output alu_op_t  alu_op,
    output logic     a_sel_pc,
    output logic     b_sel_imm,
    output logic     is_branch,
    output logic     branch_ne,
    output logic     is_load,
    output logic     is_store,
    output logic     is_csr,
    output logic     reg_wen
);
    opcode_t    opcode;
    logic [2:0] funct3;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_b;
    xlen_t      imm_u;

    assign opcode = opcode_t'(inst[6:0]);
    assign funct3 = inst[14:12];
    // Register fields are passed through raw
    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];
    assign rd  = inst[11:7];

    // Immediate formats
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};

    always_comb begin
        // Default is a bubble
        imm       = '0;
        alu_op    = ALU_ADD;
        a_sel_pc  = 1'b0;
        b_sel_imm = 1'b0;
        is_branch = 1'b0;
        branch_ne = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_csr    = 1'b0;
        reg_wen   = 1'b0;
        case (opcode)
            OPC_OP: begin
                reg_wen = 1'b1;
                case (funct3)
                    F3_ADD_SUB: alu_op = inst[30] ? ALU_SUB : ALU_ADD;
                    F3_AND:     alu_op = ALU_AND;
                    F3_OR:      alu_op = ALU_OR;
                    F3_XOR:     alu_op = ALU_XOR;
                    F3_SLT:     alu_op = ALU_SLT;
                    F3_SLL:     alu_op = ALU_SLL;
                    // sra is not supported
                    F3_SRL:     begin
                        alu_op  = ALU_SRL;
                        reg_wen = !inst[30];
                    end
                    default:    reg_wen = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                imm       = imm_i;
                b_sel_imm = 1'b1;
                reg_wen   = 1'b1;
                case (funct3)
                    F3_ADD_SUB: alu_op = ALU_ADD;
                    F3_AND:     alu_op = ALU_AND;
                    F3_OR:      alu_op = ALU_OR;
                    F3_XOR:     alu_op = ALU_XOR;
                    F3_SLT:     alu_op = ALU_SLT;
                    // No immediate shifts
                    default:    reg_wen = 1'b0;
                endcase
            end
            OPC_LUI: begin
                imm       = imm_u;
                alu_op    = ALU_PASS_B;
                b_sel_imm = 1'b1;
                reg_wen   = 1'b1;
            end
            OPC_BRANCH: begin
                // ALU forms the target from PC and offset
                imm       = imm_b;
                a_sel_pc  = 1'b1;
                b_sel_imm = 1'b1;
                is_branch = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
                branch_ne = (funct3 == F3_BNE);
            end
            OPC_LOAD: begin
                imm       = imm_i;
                b_sel_imm = 1'b1;
                is_load   = (funct3 == F3_WORD);
                reg_wen   = (funct3 == F3_WORD);
            end
            OPC_STORE: begin
                imm       = imm_s;
                b_sel_imm = 1'b1;
                is_store  = (funct3 == F3_WORD);
            end
            // csrrw only, CSR number checked in execute
            OPC_SYSTEM: is_csr = (funct3 == F3_CSRRW);
            default: ;
        endcase
    end

endmodule

// ==== mem_wb_stage.sv ====
`timescale 1ns/1ps

module mem_wb_stage import riscv_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  xlen_t    alu_out,
    input  xlen_t    store_data,
    input  logic     is_load_x,
    input  logic     is_store_x,
    input  logic     reg_wen_x,
    input  reg_idx_t rd_x,
    output logic     wb_en,
    output reg_idx_t wb_rd,
    output xlen_t    wb_val
);
    xlen_t     dmem [DMEM_WORDS];
    dmem_idx_t dmem_idx;
    xlen_t     dmem_q;
    xlen_t     alu_mw;
    logic      is_load_mw;

    // Word addressed, upper address bits ignored
    assign dmem_idx = alu_out[11:2];

    // Address comes straight from execute
    always_ff @(posedge clk) begin
        if (is_store_x) begin
            dmem[dmem_idx] <= store_data;
        end
        dmem_q <= dmem[dmem_idx];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_en      <= 1'b0;
            is_load_mw <= 1'b0;
        end else begin
            wb_en      <= reg_wen_x;
            is_load_mw <= is_load_x;
        end
    end

    always_ff @(posedge clk) begin
        alu_mw <= alu_out;
        wb_rd  <= rd_x;
    end

    // Load data arrives this cycle
    assign wb_val = is_load_mw ? dmem_q : alu_mw;

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ps

module reg_file import riscv_pkg::*; (
    input  logic     clk,
    input  logic     we,
    input  reg_idx_t ra1,
    input  reg_idx_t ra2,
    input  reg_idx_t wa,
    input  xlen_t    wd,
    output xlen_t    rd1,
    output xlen_t    rd2
);
    xlen_t regs [32];

    // x0 reads as zero whatever the array holds
    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

    always_ff @(posedge clk) begin
        if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

endmodule

// ==== riscv_pkg.sv ====
package riscv_pkg;

    // Datapath widths
    typedef logic [31:0] xlen_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_idx_t;
    // Word indices into the two memories
    typedef logic [9:0]  imem_idx_t;
    typedef logic [9:0]  dmem_idx_t;

    // ALU operations, pass-b serves lui
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B
    } alu_op_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_SYSTEM = 7'b1110011
    } opcode_t;

    // funct3 values
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL     = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_WORD    = 3'b010;
    localparam logic [2:0] F3_CSRRW   = 3'b001;

    localparam addr_t       RESET_PC   = 32'h0000_0000;
    // addi x0, x0, 0
    localparam inst_t       NOP_INST   = 32'h0000_0013;
    localparam logic [11:0] TOHOST_CSR = 12'h51E;
    localparam int          IMEM_WORDS = 1024;
    localparam int          DMEM_WORDS = 1024;

endpackage

// ==== rv_core.sv ====
`timescale 1ns/1ps

module rv_core import riscv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      run,
    input  logic      imem_wr_en,
    input  imem_idx_t imem_wr_addr,
    input  inst_t     imem_wr_data,
    output xlen_t     tohost,
    output logic      tohost_valid
);
    // Fetch/decode stage outputs
    addr_t    pc_fd;
    inst_t    inst_fd;
    xlen_t    imm;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    alu_op_t  alu_op;
    logic     a_sel_pc;
    logic     b_sel_imm;
    logic     is_branch;
    logic     branch_ne;
    logic     is_load;
    logic     is_store;
    logic     is_csr;
    logic     reg_wen;
    xlen_t    rs1_val;
    xlen_t    rs2_val;
    // Execute outputs
    logic     br_taken;
    addr_t    br_target;
    xlen_t    alu_out;
    xlen_t    store_data;
    logic     is_load_x;
    logic     is_store_x;
    logic     reg_wen_x;
    reg_idx_t rd_x;
    // Writeback port, also the forwarding source
    logic     wb_en;
    reg_idx_t wb_rd;
    xlen_t    wb_val;

    fetch_stage fetch_i (
        .clk(clk), .rst(rst), .run(run),
        .imem_wr_en(imem_wr_en), .imem_wr_addr(imem_wr_addr), .imem_wr_data(imem_wr_data),
        .br_taken(br_taken), .br_target(br_target),
        .pc_fd(pc_fd), .inst_fd(inst_fd)
    );

    inst_decoder decoder_i (
        .inst(inst_fd), .imm(imm), .rs1(rs1), .rs2(rs2), .rd(rd), .alu_op(alu_op),
        .a_sel_pc(a_sel_pc), .b_sel_imm(b_sel_imm), .is_branch(is_branch),
        .branch_ne(branch_ne), .is_load(is_load), .is_store(is_store),
        .is_csr(is_csr), .reg_wen(reg_wen)
    );

    reg_file rf_i (
        .clk(clk), .we(wb_en), .ra1(rs1), .ra2(rs2), .wa(wb_rd), .wd(wb_val),
        .rd1(rs1_val), .rd2(rs2_val)
    );

    execute_stage execute_i (
        .clk(clk), .rst(rst), .pc_fd(pc_fd), .inst_fd(inst_fd), .imm(imm),
        .rs1(rs1), .rs2(rs2), .rs1_val(rs1_val), .rs2_val(rs2_val), .rd(rd),
        .alu_op(alu_op), .a_sel_pc(a_sel_pc), .b_sel_imm(b_sel_imm),
        .is_branch(is_branch), .branch_ne(branch_ne), .is_load(is_load),
        .is_store(is_store), .is_csr(is_csr), .reg_wen(reg_wen),
        .wb_en(wb_en), .wb_rd(wb_rd), .wb_val(wb_val),
        .br_taken(br_taken), .br_target(br_target), .alu_out(alu_out),
        .store_data(store_data), .is_load_x(is_load_x), .is_store_x(is_store_x),
        .reg_wen_x(reg_wen_x), .rd_x(rd_x), .tohost(tohost), .tohost_valid(tohost_valid)
    );

    mem_wb_stage mem_wb_i (
        .clk(clk), .rst(rst), .alu_out(alu_out), .store_data(store_data),
        .is_load_x(is_load_x), .is_store_x(is_store_x), .reg_wen_x(reg_wen_x),
        .rd_x(rd_x), .wb_en(wb_en), .wb_rd(wb_rd), .wb_val(wb_val)
    );

endmodule

// ==== rv_core_properties.sv ====
`timescale 1ns/1ps

module rv_core_properties import riscv_pkg::*; (
    input logic       clk,
    input logic       rst,
    input logic       tohost_valid,
    input logic       br_taken,
    input logic [6:0] opcode_fd
);
    // Read by the testbench at the end of the run
    int failures;

    initial failures = 0;

    // csrrw slots are never adjacent so each result is one pulse
    valid_single_pulse: assert property (
        @(posedge clk) disable iff (rst) tohost_valid |=> !tohost_valid
    ) else begin
        $error("tohost_valid stayed high for two cycles");
        failures++;
    end

    // Only a branch in execute redirects fetch
    // Opcode of the raw word that entered execute
    taken_needs_branch: assert property (
        @(posedge clk) disable iff (rst) br_taken |-> $past(opcode_fd) == OPC_BRANCH
    ) else begin
        $error("br_taken without a branch in execute");
        failures++;
    end

    // Slot behind a taken branch is a bubble
    no_back_to_back_taken: assert property (
        @(posedge clk) disable iff (rst) br_taken |=> !br_taken
    ) else begin
        $error("Taken branch directly behind a taken branch");
        failures++;
    end

endmodule

bind execute_stage rv_core_properties props_i (
    .clk(clk),
    .rst(rst),
    .tohost_valid(tohost_valid),
    .br_taken(br_taken),
    .opcode_fd(inst_fd[6:0])
);

// ==== tb.f ====
riscv_pkg.sv
reg_file.sv
inst_decoder.sv
fetch_stage.sv
execute_stage.sv
mem_wb_stage.sv
rv_core.sv
tb_clock.sv
rv_core_properties.sv
tb_rv_core.sv

// ==== tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst
);
    // 100 ns period
    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 4;

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

    always #HALF_PERIOD clk = ~clk;

endmodule

// ==== tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core import riscv_pkg::*; #(
    parameter logic [31:0] SEED = 32'd38
) ();
    localparam int          PROG_LEN         = 64;
    localparam int          LAST_IDX         = PROG_LEN - 1;
    localparam int          WATCHDOG_CYCLES  = PROG_LEN * 4 + 100;
    localparam int          DRAIN_CYCLES     = 16;
    localparam logic [31:0] LFSR_TAPS        = 32'h8020_0003;

    logic      clk;
    logic      rst;
    logic      run;
    logic      imem_wr_en;
    imem_idx_t imem_wr_addr;
    inst_t     imem_wr_data;
    xlen_t     tohost;
    logic      tohost_valid;

    logic [31:0] lfsr;
    inst_t       prog [PROG_LEN];
    xlen_t       exp_q [$];
    int          pulses;
    int          checks;
    int          errors;

    tb_clock clock_i (.clk(clk), .rst(rst));

    rv_core rv_core_i (
        .clk(clk), .rst(rst), .run(run),
        .imem_wr_en(imem_wr_en), .imem_wr_addr(imem_wr_addr), .imem_wr_data(imem_wr_data),
        .tohost(tohost), .tohost_valid(tohost_valid)
    );

    // Galois LFSR stepped once per bit
    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int k = 0; k < n; k++) begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        end
        return v;
    endfunction

    // Instruction encoders
    function automatic inst_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3,
                                    input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic inst_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                    input logic [2:0] f3, input reg_idx_t rd,
                                    input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
                                    input reg_idx_t rs1);
        return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OPC_STORE};
    endfunction

    function automatic inst_t enc_b(input logic [12:0] imm, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    // Random program with a csrrw in every eighth slot and a self-loop at the end
    task automatic build_program();
        int       kind;
        int       sel;
        int       tgt;
        int       off;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        for (int i = 0; i < LAST_IDX; i++) begin
            rd  = reg_idx_t'(1 + take_bits(3) % 7);
            rs1 = reg_idx_t'(take_bits(3));
            rs2 = reg_idx_t'(take_bits(3));
            // Slot 15 reads back the word stored and loaded just before it
            if (i == 15) begin
                rs1 = 5'd7;
            end
            if (i % 8 == 7) begin
                prog[i] = {TOHOST_CSR, rs1, F3_CSRRW, 5'd0, OPC_SYSTEM};
            end else if (i < 7) begin
                // x1..x7 get known values first
                prog[i] = enc_i(12'(take_bits(12)), 5'd0, F3_ADD_SUB, reg_idx_t'(i + 1),
                                OPC_OP_IMM);
            end else if (i < 12) begin
                // Words 0..3 of data memory are written before any load
                prog[i] = enc_s(12'((i - 8) * 4), reg_idx_t'(i - 7), 5'd0);
            end else if (i == 12) begin
                // Word 1 overwritten with x5 and read straight back
                prog[i] = enc_s(12'd4, 5'd5, 5'd0);
            end else if (i == 13) begin
                prog[i] = enc_i(12'd4, 5'd0, F3_WORD, 5'd6, OPC_LOAD);
            end else if (i == 14) begin
                prog[i] = enc_r(7'h00, 5'd0, 5'd6, F3_ADD_SUB, 5'd7);
            end else begin
                kind = take_bits(3);
                case (kind)
                    0, 1: begin
                        sel = take_bits(3);
                        case (sel)
                            0: prog[i] = enc_r(7'h00, rs2, rs1, F3_ADD_SUB, rd);
                            1: prog[i] = enc_r(7'h20, rs2, rs1, F3_ADD_SUB, rd);
                            2: prog[i] = enc_r(7'h00, rs2, rs1, F3_AND, rd);
                            3: prog[i] = enc_r(7'h00, rs2, rs1, F3_OR, rd);
                            4: prog[i] = enc_r(7'h00, rs2, rs1, F3_XOR, rd);
                            5: prog[i] = enc_r(7'h00, rs2, rs1, F3_SLT, rd);
                            6: prog[i] = enc_r(7'h00, rs2, rs1, F3_SLL, rd);
                            default: prog[i] = enc_r(7'h00, rs2, rs1, F3_SRL, rd);
                        endcase
                    end
                    2, 3: begin
                        sel = take_bits(3) % 5;
                        case (sel)
                            0: prog[i] = enc_i(12'(take_bits(12)), rs1, F3_ADD_SUB, rd, OPC_OP_IMM);
                            1: prog[i] = enc_i(12'(take_bits(12)), rs1, F3_AND, rd, OPC_OP_IMM);
                            2: prog[i] = enc_i(12'(take_bits(12)), rs1, F3_OR, rd, OPC_OP_IMM);
                            3: prog[i] = enc_i(12'(take_bits(12)), rs1, F3_XOR, rd, OPC_OP_IMM);
                            default: prog[i] = enc_i(12'(take_bits(12)), rs1, F3_SLT, rd,
                                                     OPC_OP_IMM);
                        endcase
                    end
                    4: prog[i] = {20'(take_bits(20)), rd, OPC_LUI};
                    5: begin
                        // Forward jump over one to four slots
                        tgt = i + 2 + take_bits(2);
                        if (tgt > LAST_IDX) begin
                            tgt = LAST_IDX;
                        end
                        off = (tgt - i) * 4;
                        sel = take_bits(1);
                        prog[i] = enc_b(off[12:0], rs2, rs1, (sel == 1) ? F3_BNE : F3_BEQ);
                    end
                    6: prog[i] = enc_i(12'(take_bits(2) * 4), 5'd0, F3_WORD, rd, OPC_LOAD);
                    default: prog[i] = enc_s(12'(take_bits(2) * 4), rs2, 5'd0);
                endcase
            end
        end
        prog[LAST_IDX] = enc_b(13'd0, 5'd0, 5'd0, F3_BEQ);
    endtask

    // ISA semantics of the register-register and immediate ops
    function automatic xlen_t alu_ref(input logic [2:0] f3, input logic sub,
                                      input xlen_t a, input xlen_t b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // Instruction-level interpreter that records every tohost write
    task automatic run_model();
        xlen_t    regs [32];
        xlen_t    dmem [16];
        int       pc;
        int       next;
        int       steps;
        inst_t    w;
        reg_idx_t rd;
        xlen_t    a;
        xlen_t    b;
        xlen_t    imm_i;
        xlen_t    imm_s;
        xlen_t    imm_b;
        xlen_t    res;
        logic     wr;
        for (int k = 0; k < 32; k++) begin
            regs[k] = '0;
        end
        for (int k = 0; k < 16; k++) begin
            dmem[k] = '0;
        end
        pc = 0;
        steps = 0;
        while (pc != LAST_IDX && steps < 1000) begin
            w     = prog[pc];
            rd    = w[11:7];
            a     = regs[w[19:15]];
            b     = regs[w[24:20]];
            imm_i = {{20{w[31]}}, w[31:20]};
            imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
            imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            wr    = 1'b0;
            res   = '0;
            next  = pc + 1;
            case (w[6:0])
                7'b0110011: begin
                    res = alu_ref(w[14:12], w[30], a, b);
                    wr  = 1'b1;
                end
                7'b0010011: begin
                    res = alu_ref(w[14:12], 1'b0, a, imm_i);
                    wr  = 1'b1;
                end
                7'b0110111: begin
                    res = {w[31:12], 12'b0};
                    wr  = 1'b1;
                end
                7'b1100011: begin
                    if ((w[14:12] == 3'b001) ? (a != b) : (a == b)) begin
                        next = pc + int'($signed(imm_b) >>> 2);
                    end
                end
                7'b0000011: begin
                    res = dmem[imm_i[5:2]];
                    wr  = 1'b1;
                end
                7'b0100011: dmem[imm_s[5:2]] = b;
                7'b1110011: begin
                    if (w[31:20] == 12'h51E) begin
                        exp_q.push_back(a);
                    end
                end
                default: ;
            endcase
            if (wr && rd != 5'd0) begin
                regs[rd] = res;
            end
            pc = next;
            steps++;
        end
    endtask

    task automatic check_value(input xlen_t got, input xlen_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic print_summary();
        $display("Checks: %0d, errors: %0d, assertion failures: %0d, tohost pulses: %0d",
                 checks, errors, rv_core_i.execute_i.props_i.failures, pulses);
    endtask

    // One word per cycle while the core is parked
    task automatic load_program();
        for (int i = 0; i < PROG_LEN; i++) begin
            @(posedge clk);
            imem_wr_en   <= 1'b1;
            imem_wr_addr <= imem_idx_t'(i);
            imem_wr_data <= prog[i];
        end
        @(posedge clk);
        imem_wr_en <= 1'b0;
    endtask

    // Outputs sampled mid-cycle
    always @(negedge clk) begin
        if (!rst && !run) begin
            check_flag(tohost_valid, 1'b0, "tohost_valid before run");
            check_value(tohost, '0, "tohost before run");
        end else if (run && tohost_valid) begin
            if (pulses < exp_q.size()) begin
                check_value(tohost, exp_q[pulses], "tohost");
            end else begin
                errors++;
                $display("Extra tohost pulse with value %h, the model writes only %0d values",
                         tohost, exp_q.size());
            end
            pulses++;
        end
    end

    initial begin
        run          = 1'b0;
        imem_wr_en   = 1'b0;
        imem_wr_addr = '0;
        imem_wr_data = '0;
        pulses       = 0;
        checks       = 0;
        errors       = 0;
        lfsr         = SEED;
        build_program();
        run_model();
        @(posedge clk);
        while (rst) begin
            @(posedge clk);
        end
        load_program();
        @(posedge clk);
        run <= 1'b1;
        wait (pulses == exp_q.size());
        // Room for any stray pulse behind the last one
        repeat (DRAIN_CYCLES) @(posedge clk);
        check_count(pulses, exp_q.size(), "tohost pulse count");
        print_summary();
        if (errors == 0 && rv_core_i.execute_i.props_i.failures == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Bounded by the program length
    initial begin
        wait (run);
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: only %0d of %0d tohost results arrived", pulses, exp_q.size());
        print_summary();
        $display("Something failed");
        $finish;
    end

endmodule
